// File: design/dcache_geom_pkg.sv
package dcache_geom_pkg;

    // one-word lines, so the offset only selects a byte
    localparam int SET_NUM  = 64;
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 2;
    localparam int TAG_W    = 32 - INDEX_W - OFFSET_W;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } paddr_fields_t;

    // physical address, seen as a plain word or split into fields
    typedef union packed {
        logic [31:0]   raw;
        paddr_fields_t f;
    } paddr_u;

    // one row of a tag array
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
    } tag_entry_t;

endpackage

// File: design/lsu_op_pkg.sv
package lsu_op_pkg;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    typedef struct packed {
        dcache_geom_pkg::paddr_u addr;
        mem_size_e               size;
        logic                    is_signed;
        logic [3:0]              mask;
    } load_req_t;

    typedef struct packed {
        dcache_geom_pkg::paddr_u addr;
        logic [31:0]             data;
        logic [3:0]              strb;
        logic                    valid;
    } sb_entry_t;

    // bytes touched by an access of the given size at the given offset
    function automatic logic [3:0] byte_mask(
        input mem_size_e                             size,
        input logic [dcache_geom_pkg::OFFSET_W-1:0] offset
    );
        logic [3:0] mask;
        case (size)
            SIZE_BYTE: mask = 4'b0001 << offset;
            SIZE_HALF: mask = 4'b0011 << {offset[1], 1'b0};
            default:   mask = 4'b1111;
        endcase
        return mask;
    endfunction

endpackage

// File: design/way_if.sv
`timescale 1ns/1ps

interface way_if;

    // lookup side, sampled by the way at the clock edge
    logic [dcache_geom_pkg::INDEX_W-1:0] lk_index;
    logic [dcache_geom_pkg::TAG_W-1:0]   lk_tag;

    // write side, refill or store drain
    logic                                wr_en;
    logic [dcache_geom_pkg::INDEX_W-1:0] wr_index;
    logic [dcache_geom_pkg::TAG_W-1:0]   wr_tag;
    logic [31:0]                         wr_data;
    logic [3:0]                          wr_strb;
    logic                                wr_refill;

    logic                                hit;
    logic [31:0]                         rd_data;

    modport req (output lk_index, lk_tag, wr_en, wr_index, wr_tag, wr_data, wr_strb, wr_refill);

    modport way (input lk_index, lk_tag, wr_en, wr_index, wr_tag, wr_data, wr_strb, wr_refill,
                 output hit, rd_data);

    modport mon (input hit, rd_data);

endinterface

// File: design/dcache_way.sv
`timescale 1ns/1ps

module dcache_way (
    input logic clk,
    input logic rst_n_i,
    way_if.way  port
);

    localparam int SET_NUM = dcache_geom_pkg::SET_NUM;

    logic [dcache_geom_pkg::TAG_W-1:0]   tag_arr [SET_NUM];
    logic [31:0]                         data_arr [SET_NUM];
    logic [SET_NUM-1:0]                  valid_q;
    logic [dcache_geom_pkg::INDEX_W-1:0] idx_q;
    logic [dcache_geom_pkg::TAG_W-1:0]   tag_q;
    dcache_geom_pkg::tag_entry_t         rd_row;
    dcache_geom_pkg::tag_entry_t         wr_row;
    logic                                wr_hit;
    logic                                wr_take;

    // lookup registered, arrays read after it so same-edge writes show up
    always_ff @(posedge clk) begin
        idx_q <= port.lk_index;
        tag_q <= port.lk_tag;
    end

    assign rd_row       = {tag_arr[idx_q], valid_q[idx_q]};
    assign port.hit     = rd_row.valid & (rd_row.tag == tag_q);
    assign port.rd_data = data_arr[idx_q];

    // drain writes only land on a matching line
    assign wr_row  = {tag_arr[port.wr_index], valid_q[port.wr_index]};
    assign wr_hit  = wr_row.valid & (wr_row.tag == port.wr_tag);
    assign wr_take = port.wr_en & (port.wr_refill | wr_hit);

    always_ff @(posedge clk) begin
        if (wr_take) begin
            for (int b = 0; b < 4; b++) begin
                if (port.wr_strb[b]) begin
                    data_arr[port.wr_index][8*b +: 8] <= port.wr_data[8*b +: 8];
                end
            end
            if (port.wr_refill) begin
                tag_arr[port.wr_index] <= port.wr_tag;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (port.wr_en && port.wr_refill) begin
            valid_q[port.wr_index] <= 1'b1;
        end
    end

endmodule

// File: design/store_buffer.sv
`timescale 1ns/1ps

module store_buffer #(
    parameter int SB_SIZE = 4
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  store_valid_i,
    input  logic [31:0]           store_addr_i,
    input  logic [31:0]           store_data_i,
    input  lsu_op_pkg::mem_size_e store_size_i,
    input  logic                  drain_i,
    output lsu_op_pkg::sb_entry_t oldest_o,
    output logic                  full_o,
    input  logic [31:0]           fwd_addr_i,
    output logic [3:0]            fwd_mask_o,
    output logic [31:0]           fwd_data_o
);

    localparam int PTR_W = (SB_SIZE > 1) ? $clog2(SB_SIZE) : 1;
    localparam int CNT_W = $clog2(SB_SIZE + 1);
    localparam int OFF_W = dcache_geom_pkg::OFFSET_W;

    lsu_op_pkg::sb_entry_t entries_q [SB_SIZE];
    lsu_op_pkg::sb_entry_t new_entry;
    logic [PTR_W-1:0]      head_q;
    logic [PTR_W-1:0]      tail_q;
    logic [CNT_W-1:0]      count_q;
    logic                  push;
    logic                  pop;
    logic [3:0]            fwd_mask_d;
    logic [31:0]           fwd_data_d;
    logic [3:0]            fwd_mask_q;
    logic [31:0]           fwd_data_q;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(SB_SIZE - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o   = (count_q == CNT_W'(SB_SIZE));
    assign push     = store_valid_i & ~full_o;
    assign pop      = drain_i & entries_q[head_q].valid;
    assign oldest_o = entries_q[head_q];

    // store data arrives in the low bytes, moved to its lanes here
    always_comb begin
        new_entry.addr.raw = store_addr_i;
        new_entry.data     = store_data_i << {store_addr_i[OFF_W-1:0], 3'b000};
        new_entry.strb     = lsu_op_pkg::byte_mask(store_size_i, store_addr_i[OFF_W-1:0]);
        new_entry.valid    = 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < SB_SIZE; i++) begin
                entries_q[i] <= '0;
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            for (int i = 0; i < SB_SIZE; i++) begin
                entries_q[i] <= '0;
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                entries_q[tail_q] <= new_entry;
                tail_q            <= ptr_inc(tail_q);
            end
            if (pop) begin
                entries_q[head_q].valid <= 1'b0;
                head_q                  <= ptr_inc(head_q);
            end
            count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // walk from oldest to youngest, later matches overwrite earlier ones
    always_comb begin
        int idx;
        fwd_mask_d = '0;
        fwd_data_d = '0;
        for (int k = 0; k < SB_SIZE; k++) begin
            idx = (int'(head_q) + k) % SB_SIZE;
            if (entries_q[idx].valid &&
                entries_q[idx].addr.raw[31:OFF_W] == fwd_addr_i[31:OFF_W]) begin
                for (int b = 0; b < 4; b++) begin
                    if (entries_q[idx].strb[b]) begin
                        fwd_mask_d[b]        = 1'b1;
                        fwd_data_d[8*b +: 8] = entries_q[idx].data[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fwd_mask_q <= '0;
        end else begin
            fwd_mask_q <= flush_i ? '0 : fwd_mask_d;
        end
    end

    always_ff @(posedge clk) begin
        fwd_data_q <= fwd_data_d;
    end

    assign fwd_mask_o = fwd_mask_q;
    assign fwd_data_o = fwd_data_q;

endmodule

// File: design/lsu_req_stage.sv
`timescale 1ns/1ps

module lsu_req_stage #(
    parameter int WAY_NUM = 2
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  load_valid_i,
    input  logic [31:0]           load_addr_i,
    input  lsu_op_pkg::mem_size_e load_size_i,
    input  logic                  load_signed_i,
    input  logic                  commit_i,
    input  logic                  refill_valid_i,
    input  logic [31:0]           refill_addr_i,
    input  logic [31:0]           refill_data_i,
    input  lsu_op_pkg::sb_entry_t drain_entry_i,
    output logic                  drain_o,
    output lsu_op_pkg::load_req_t req_o,
    output logic                  req_valid_o,
    way_if.req                    ways [WAY_NUM-1:0]
);

    localparam int VIC_W = (WAY_NUM > 1) ? $clog2(WAY_NUM) : 1;

    dcache_geom_pkg::paddr_u load_pa;
    dcache_geom_pkg::paddr_u refill_pa;
    dcache_geom_pkg::paddr_u wr_pa;
    lsu_op_pkg::load_req_t   req_d;
    lsu_op_pkg::load_req_t   req_q;
    logic                    valid_q;
    logic                    commit_pend_q;
    logic                    drain_req;
    logic [VIC_W-1:0]        victim_q;
    logic [31:0]             wr_data;
    logic [3:0]              wr_strb;

    assign load_pa.raw   = load_addr_i;
    assign refill_pa.raw = refill_addr_i;

    // a commit lost to a refill is retried next cycle
    assign drain_req = commit_i | commit_pend_q;
    assign drain_o   = drain_req & ~refill_valid_i & ~flush_i & drain_entry_i.valid;

    // refill has priority over the drain
    assign wr_pa   = refill_valid_i ? refill_pa : drain_entry_i.addr;
    assign wr_data = refill_valid_i ? refill_data_i : drain_entry_i.data;
    assign wr_strb = refill_valid_i ? 4'b1111 : drain_entry_i.strb;

    always_comb begin
        req_d.addr      = load_pa;
        req_d.size      = load_size_i;
        req_d.is_signed = load_signed_i;
        req_d.mask      = lsu_op_pkg::byte_mask(load_size_i, load_pa.f.offset);
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q       <= 1'b0;
            commit_pend_q <= 1'b0;
            victim_q      <= '0;
        end else begin
            valid_q       <= load_valid_i & ~flush_i;
            commit_pend_q <= drain_req & refill_valid_i & ~flush_i;
            if (refill_valid_i) begin
                victim_q <= (victim_q == VIC_W'(WAY_NUM - 1)) ? '0 : victim_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_valid_i) begin
            req_q <= req_d;
        end
    end

    assign req_o = req_q;
    // a flush also kills the load answering in this cycle
    assign req_valid_o = valid_q & ~flush_i;

    for (genvar g = 0; g < WAY_NUM; g++) begin : g_way_drive
        assign ways[g].lk_index  = load_pa.f.index;
        assign ways[g].lk_tag    = load_pa.f.tag;
        assign ways[g].wr_en     = refill_valid_i ? (victim_q == VIC_W'(g)) : drain_o;
        assign ways[g].wr_index  = wr_pa.f.index;
        assign ways[g].wr_tag    = wr_pa.f.tag;
        assign ways[g].wr_data   = wr_data;
        assign ways[g].wr_strb   = wr_strb;
        assign ways[g].wr_refill = refill_valid_i;
    end

endmodule

// File: design/load_merge.sv
`timescale 1ns/1ps

module load_merge #(
    parameter int WAY_NUM = 2
) (
    input  lsu_op_pkg::load_req_t req_i,
    input  logic                  req_valid_i,
    input  logic [3:0]            fwd_mask_i,
    input  logic [31:0]           fwd_data_i,
    way_if.mon                    ways [WAY_NUM-1:0],
    output logic                  resp_valid_o,
    output logic                  hit_o,
    output logic [31:0]           data_o
);

    logic [WAY_NUM-1:0] way_hit;
    logic [31:0]        way_data [WAY_NUM];
    logic [31:0]        cache_word;
    logic [31:0]        merged;
    logic [31:0]        shifted;
    logic [31:0]        extended;
    logic [3:0]         covered;
    logic               all_covered;

    for (genvar g = 0; g < WAY_NUM; g++) begin : g_way_read
        assign way_hit[g]  = ways[g].hit;
        assign way_data[g] = ways[g].rd_data;
    end

    // at most one way hits, so an OR is enough
    always_comb begin
        cache_word = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            if (way_hit[w]) begin
                cache_word = cache_word | way_data[w];
            end
        end
    end

    // forwarded bytes override the cache
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = fwd_mask_i[b] ? fwd_data_i[8*b +: 8] : cache_word[8*b +: 8];
        end
    end

    assign covered     = (|way_hit) ? 4'b1111 : fwd_mask_i;
    assign all_covered = ((req_i.mask & ~covered) == 4'b0000);

    assign shifted = merged >> {req_i.addr.f.offset, 3'b000};

    always_comb begin
        case (req_i.size)
            lsu_op_pkg::SIZE_BYTE:
                extended = {{24{req_i.is_signed & shifted[7]}}, shifted[7:0]};
            lsu_op_pkg::SIZE_HALF:
                extended = {{16{req_i.is_signed & shifted[15]}}, shifted[15:0]};
            default:
                extended = shifted;
        endcase
    end

    assign resp_valid_o = req_valid_i;
    assign hit_o        = all_covered;
    // miss returns zero
    assign data_o       = all_covered ? extended : 32'h0;

endmodule

// File: design/dcache_lsu_top.sv
`timescale 1ns/1ps

module dcache_lsu_top #(
    parameter int WAY_NUM = 2,
    parameter int SB_SIZE = 4
) (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        flush_i,
    input  logic        load_valid_i,
    input  logic [31:0] load_addr_i,
    input  logic [1:0]  load_size_i,
    input  logic        load_signed_i,
    output logic        load_resp_valid_o,
    output logic        load_hit_o,
    output logic [31:0] load_data_o,
    input  logic        store_valid_i,
    input  logic [31:0] store_addr_i,
    input  logic [31:0] store_data_i,
    input  logic [1:0]  store_size_i,
    output logic        sb_full_o,
    input  logic        commit_i,
    input  logic        refill_valid_i,
    input  logic [31:0] refill_addr_i,
    input  logic [31:0] refill_data_i
);

    lsu_op_pkg::load_req_t req;
    logic                  req_valid;
    lsu_op_pkg::sb_entry_t oldest;
    logic                  drain;
    logic [3:0]            fwd_mask;
    logic [31:0]           fwd_data;

    way_if ways [WAY_NUM-1:0] ();

    lsu_req_stage #(
        .WAY_NUM(WAY_NUM)
    ) u_req_stage (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .load_valid_i  (load_valid_i),
        .load_addr_i   (load_addr_i),
        .load_size_i   (lsu_op_pkg::mem_size_e'(load_size_i)),
        .load_signed_i (load_signed_i),
        .commit_i      (commit_i),
        .refill_valid_i(refill_valid_i),
        .refill_addr_i (refill_addr_i),
        .refill_data_i (refill_data_i),
        .drain_entry_i (oldest),
        .drain_o       (drain),
        .req_o         (req),
        .req_valid_o   (req_valid),
        .ways          (ways)
    );

    store_buffer #(
        .SB_SIZE(SB_SIZE)
    ) u_store_buffer (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .store_valid_i(store_valid_i),
        .store_addr_i (store_addr_i),
        .store_data_i (store_data_i),
        .store_size_i (lsu_op_pkg::mem_size_e'(store_size_i)),
        .drain_i      (drain),
        .oldest_o     (oldest),
        .full_o       (sb_full_o),
        .fwd_addr_i   (load_addr_i),
        .fwd_mask_o   (fwd_mask),
        .fwd_data_o   (fwd_data)
    );

    for (genvar g = 0; g < WAY_NUM; g++) begin : g_way
        dcache_way u_way (
            .clk    (clk),
            .rst_n_i(rst_n_i),
            .port   (ways[g])
        );
    end

    load_merge #(
        .WAY_NUM(WAY_NUM)
    ) u_load_merge (
        .req_i       (req),
        .req_valid_i (req_valid),
        .fwd_mask_i  (fwd_mask),
        .fwd_data_i  (fwd_data),
        .ways        (ways),
        .resp_valid_o(load_resp_valid_o),
        .hit_o       (load_hit_o),
        .data_o      (load_data_o)
    );

endmodule

// File: testbench/tb_dcache_lsu.sv
`timescale 1ns/1ps

module tb_dcache_lsu;

    localparam int    MAX_LINES    = 128;
    localparam int    FIELDS       = 8;
    localparam int    RESET_CYCLES = 10;
    localparam int    SB_ENTRIES   = 4;
    localparam string GOLDEN_FILE  = "testbench/dcache_golden.txt";

    // operation codes of the golden script
    localparam logic [31:0] OP_LOAD   = 32'h1;
    localparam logic [31:0] OP_STORE  = 32'h2;
    localparam logic [31:0] OP_COMMIT = 32'h3;
    localparam logic [31:0] OP_REFILL = 32'h4;
    localparam logic [31:0] OP_FLUSH  = 32'h5;
    localparam logic [31:0] OP_END    = 32'hf;

    logic        clk;
    logic        rst_n_i;
    logic        flush_i;
    logic        load_valid_i;
    logic [31:0] load_addr_i;
    logic [1:0]  load_size_i;
    logic        load_signed_i;
    logic        load_resp_valid_o;
    logic        load_hit_o;
    logic [31:0] load_data_o;
    logic        store_valid_i;
    logic [31:0] store_addr_i;
    logic [31:0] store_data_i;
    logic [1:0]  store_size_i;
    logic        sb_full_o;
    logic        commit_i;
    logic        refill_valid_i;
    logic [31:0] refill_addr_i;
    logic [31:0] refill_data_i;

    logic [31:0] golden [MAX_LINES*FIELDS];
    int          line_num;
    int          cycle_cnt;
    int          cycle_limit;
    int          fd;
    int          sb_count;

    dcache_lsu_top #(
        .WAY_NUM(2),
        .SB_SIZE(SB_ENTRIES)
    ) i_dut (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .load_valid_i     (load_valid_i),
        .load_addr_i      (load_addr_i),
        .load_size_i      (load_size_i),
        .load_signed_i    (load_signed_i),
        .load_resp_valid_o(load_resp_valid_o),
        .load_hit_o       (load_hit_o),
        .load_data_o      (load_data_o),
        .store_valid_i    (store_valid_i),
        .store_addr_i     (store_addr_i),
        .store_data_i     (store_data_i),
        .store_size_i     (store_size_i),
        .sb_full_o        (sb_full_o),
        .commit_i         (commit_i),
        .refill_valid_i   (refill_valid_i),
        .refill_addr_i    (refill_addr_i),
        .refill_data_i    (refill_data_i)
    );

    always #20 clk = ~clk;

    task automatic stop_with_failure();
        $display("Regression failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_resp_valid(input logic got, input logic exp, input int step);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: step %0d response valid is %b, expected %b",
                     $time, step, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_hit(input logic got, input logic exp, input int step);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: step %0d hit is %b, expected %b",
                     $time, step, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input int step);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: step %0d load data is %h, expected %h",
                     $time, step, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_full(input logic got, input logic exp, input int step);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: step %0d store buffer full is %b, expected %b",
                     $time, step, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic drive_idle();
        load_valid_i   <= 1'b0;
        store_valid_i  <= 1'b0;
        commit_i       <= 1'b0;
        refill_valid_i <= 1'b0;
        flush_i        <= 1'b0;
    endtask

    task automatic drive_step(input int step);
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [1:0]  size;
        op   = golden[step*FIELDS];
        addr = golden[step*FIELDS+1];
        data = golden[step*FIELDS+2];
        size = golden[step*FIELDS+3][1:0];
        if (op > OP_FLUSH) begin
            $display("Golden step %0d has an unknown operation code %h", step, op);
            stop_with_failure();
        end
        load_valid_i   <= (op == OP_LOAD);
        load_addr_i    <= addr;
        load_size_i    <= size;
        load_signed_i  <= golden[step*FIELDS+4][0];
        store_valid_i  <= (op == OP_STORE);
        store_addr_i   <= addr;
        store_data_i   <= data;
        store_size_i   <= size;
        commit_i       <= (op == OP_COMMIT);
        refill_valid_i <= (op == OP_REFILL);
        refill_addr_i  <= addr;
        refill_data_i  <= data;
        flush_i        <= (op == OP_FLUSH);
    endtask

    // store buffer occupancy as the script fills and drains it
    task automatic track_occupancy(input int step);
        logic [31:0] op;
        op = golden[step*FIELDS];
        if (op == OP_FLUSH) begin
            sb_count = 0;
        end else if (op == OP_STORE && sb_count < SB_ENTRIES) begin
            sb_count++;
        end else if (op == OP_COMMIT && sb_count > 0) begin
            sb_count--;
        end
    endtask

    // a load answers in the cycle after it was sampled
    task automatic verify_step(input int step);
        logic exp_valid;
        exp_valid = golden[step*FIELDS+5][0];
        check_resp_valid(load_resp_valid_o, exp_valid, step);
        if (exp_valid) begin
            check_hit(load_hit_o, golden[step*FIELDS+6][0], step);
            check_data(load_data_o, golden[step*FIELDS+7], step);
        end
        track_occupancy(step);
        check_full(sb_full_o, (sb_count == SB_ENTRIES), step);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run went past %0d clock cycles", cycle_limit);
            stop_with_failure();
        end
    end

    initial begin
        clk            = 1'b0;
        cycle_cnt      = 0;
        sb_count       = 0;
        cycle_limit    = MAX_LINES + RESET_CYCLES + 20;
        rst_n_i        <= 1'b0;
        load_addr_i    <= '0;
        load_size_i    <= '0;
        load_signed_i  <= 1'b0;
        store_addr_i   <= '0;
        store_data_i   <= '0;
        store_size_i   <= '0;
        refill_addr_i  <= '0;
        refill_data_i  <= '0;
        drive_idle();

        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the golden file %s", GOLDEN_FILE);
            stop_with_failure();
        end
        $fclose(fd);
        for (int i = 0; i < MAX_LINES*FIELDS; i++) begin
            golden[i] = '0;
        end
        $readmemh(GOLDEN_FILE, golden);

        // script length up to the end marker
        line_num = 0;
        while (line_num < MAX_LINES && golden[line_num*FIELDS] != OP_END) begin
            line_num++;
        end
        if (line_num == MAX_LINES) begin
            $display("The golden file has no end marker");
            stop_with_failure();
        end
        cycle_limit = line_num + RESET_CYCLES + 20;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;

        for (int i = 0; i <= line_num; i++) begin
            @(posedge clk);
            if (i < line_num) begin
                drive_step(i);
            end else begin
                drive_idle();
            end
            @(negedge clk);
            if (i > 0) begin
                verify_step(i - 1);
            end
        end

        $display("Regression passed");
        $finish;
    end

endmodule

// File: testbench/dcache_golden.txt
// op addr data size signed exp_valid exp_hit exp_data, all hex, one line per cycle
// op 0 idle, 1 load, 2 store, 3 commit, 4 refill, 5 flush, f end; size 0 byte, 1 half, 2 word
// cold miss, refill, then hit
1 00001014 00000000 2 0 1 0 00000000
4 00001014 a5c37e81 2 0 0 0 00000000
1 00001014 00000000 2 0 1 1 a5c37e81
// byte and half loads at each offset
1 00001014 00000000 0 0 1 1 00000081
1 00001014 00000000 0 1 1 1 ffffff81
1 00001015 00000000 0 1 1 1 0000007e
1 00001016 00000000 0 1 1 1 ffffffc3
1 00001017 00000000 0 0 1 1 000000a5
1 00001017 00000000 0 1 1 1 ffffffa5
1 00001014 00000000 1 1 1 1 00007e81
1 00001016 00000000 1 1 1 1 ffffa5c3
1 00001016 00000000 1 0 1 1 0000a5c3
// forwarding to a line that is not cached, youngest store wins
2 00004021 000000aa 0 0 0 0 00000000
1 00004021 00000000 0 0 1 1 000000aa
1 00004020 00000000 2 0 1 0 00000000
2 00004022 0000bbcc 1 0 0 0 00000000
2 00004021 000000dd 0 0 0 0 00000000
2 00004020 000000ee 0 0 0 0 00000000
1 00004020 00000000 2 0 1 1 bbccddee
1 00004021 00000000 0 0 1 1 000000dd
// drains to the absent line allocate nothing
3 00000000 00000000 0 0 0 0 00000000
3 00000000 00000000 0 0 0 0 00000000
1 00004022 00000000 1 0 1 0 00000000
3 00000000 00000000 0 0 0 0 00000000
3 00000000 00000000 0 0 0 0 00000000
1 00004020 00000000 2 0 1 0 00000000
// stores over a cached line, merged, then drained into the way
2 00001017 0000005a 0 0 0 0 00000000
2 00001014 00001234 1 0 0 0 00000000
1 00001014 00000000 2 0 1 1 5ac31234
3 00000000 00000000 0 0 0 0 00000000
3 00000000 00000000 0 0 0 0 00000000
1 00001014 00000000 2 0 1 1 5ac31234
1 00001017 00000000 0 1 1 1 0000005a
// third line in set 5 evicts the first by round robin
4 00002014 b0b1b2b3 2 0 0 0 00000000
4 00003014 c0c1c2c3 2 0 0 0 00000000
1 00001014 00000000 2 0 1 0 00000000
1 00002014 00000000 2 0 1 1 b0b1b2b3
1 00003014 00000000 2 0 1 1 c0c1c2c3
// flush drops pending stores and the load in flight
4 00006040 600d600d 2 0 0 0 00000000
2 00006040 000000ff 0 0 0 0 00000000
2 00006042 00001111 1 0 0 0 00000000
1 00006040 00000000 2 0 0 0 00000000
5 00000000 00000000 0 0 0 0 00000000
1 00006040 00000000 2 0 1 1 600d600d
3 00000000 00000000 0 0 0 0 00000000
1 00006040 00000000 2 0 1 1 600d600d
f 00000000 00000000 0 0 0 0 00000000

// File: dcache_lsu_top.f
design/dcache_geom_pkg.sv
design/lsu_op_pkg.sv
design/way_if.sv
design/dcache_way.sv
design/store_buffer.sv
design/lsu_req_stage.sv
design/load_merge.sv
design/dcache_lsu_top.sv
testbench/tb_dcache_lsu.sv

// File: Makefile
TOP = tb_dcache_lsu
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): dcache_lsu_top.f $(wildcard design/*.sv) testbench/tb_dcache_lsu.sv
	verilator --binary --timing -Wno-fatal -f dcache_lsu_top.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "Regression passed" $(LOG)

lint:
	verilator --lint-only -Wall -f dcache_lsu_top.f --top-module dcache_lsu_top

clean:
	rm -rf obj_dir $(LOG)
